// ==== common/spad_params.svh ====
`ifndef SPAD_PARAMS_SVH
`define SPAD_PARAMS_SVH

// ================================================
// Bus widths
// ================================================

// Lane to core, core to lane and external memory words.
`define SPAD_DATA_W 32

// Enables, selects and modes, one bit per group each.
`define SPAD_INST_W 12

// ================================================
// Scratchpad geometry
// ================================================

// Bank groups, one lane per group.
`define SPAD_NUM_BG 4

// Words per bank group.
`define SPAD_BG_DEPTH 16

// log2 of the bank depth.
`define SPAD_PTR_W 4

`endif

// ==== common/spad_pkg.sv ====
`default_nettype none

`include "spad_params.svh"

package spad_pkg;

	// ================================================
	// Shared vector types
	// ================================================

	// One data word on any of the data buses.
	typedef logic [`SPAD_DATA_W-1:0] spad_word_t;

	// Raw instruction word.
	// [11:8] per-group enables
	// [7:4]  per-group source selects, 1 takes the lane return
	// [3:0]  per-group modes
	typedef logic [`SPAD_INST_W-1:0] spad_inst_t;

	// Write or read pointer into one bank group.
	typedef logic [`SPAD_PTR_W-1:0] spad_ptr_t;

	// One bit per bank group.
	typedef logic [`SPAD_NUM_BG-1:0] spad_grp_t;

	// Meaning of a group's mode bit.
	typedef enum logic {
		BG_FILL  = 1'b0,
		BG_DRAIN = 1'b1
	} bg_mode_e;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

# Build the testbench with assertions enabled.
verilator --binary --assert -Wno-fatal --top-module tb_spad_top -f sim.f -o tb_spad_top

# A failing check ends in $fatal, which gives a non-zero exit status.
./obj_dir/tb_spad_top

// ==== scratchpad/bankgroup.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "spad_params.svh"

module bankgroup
	import spad_pkg::*;
#(
	parameter int BG_DEPTH = `SPAD_BG_DEPTH
) (
	input  wire logic       clk,
	input  wire logic       arst_n,
	input  wire logic       en,
	input  wire logic       flush,
	input  wire bg_mode_e   pattern,
	input  wire spad_word_t din,
	output spad_word_t      dout,
	output logic            dout_valid
);

	spad_word_t mem [BG_DEPTH];

	spad_ptr_t wr_ptr;
	spad_ptr_t rd_ptr;

	logic fill_op;
	logic drain_op;

	// Next pointer, wrapping at the bank depth.
	function automatic spad_ptr_t ptr_inc(input spad_ptr_t ptr);
		spad_ptr_t nxt;
		if (ptr == spad_ptr_t'(BG_DEPTH - 1)) begin
			nxt = '0;
		end else begin
			nxt = ptr + 1'b1;
		end
		return nxt;
	endfunction

	// Flush wins over any operation in the same cycle.
	assign fill_op  = en && !flush && (pattern == BG_FILL);
	assign drain_op = en && !flush && (pattern == BG_DRAIN);

	// ================================================
	// Pointers and read strobe
	// ================================================

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			dout_valid <= 1'b0;
		end else if (flush) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			dout_valid <= 1'b0;
		end else begin
			dout_valid <= drain_op;
			if (fill_op) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (drain_op) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
		end
	end

	// ================================================
	// Storage and registered read port
	// ================================================

	always_ff @(posedge clk) begin
		if (fill_op) begin
			mem[wr_ptr] <= din;
		end
	end

	// Holds the last drained word between strobes.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dout <= '0;
		end else if (drain_op) begin
			dout <= mem[rd_ptr];
		end
	end

endmodule

`default_nettype wire

// ==== scratchpad/scratchpad.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "spad_params.svh"

module scratchpad
	import spad_pkg::*;
(
	input  wire logic       clk,
	input  wire logic       arst_n,
	input  wire spad_grp_t  grp_en,
	input  wire spad_grp_t  grp_sel,
	input  wire spad_grp_t  grp_mode,
	input  wire spad_word_t ext_word,
	input  wire logic       flush,
	input  wire spad_word_t switch_in_0,
	input  wire spad_word_t switch_in_1,
	input  wire spad_word_t switch_in_2,
	input  wire spad_word_t switch_in_3,
	output spad_word_t      switch_out_0,
	output spad_word_t      switch_out_1,
	output spad_word_t      switch_out_2,
	output spad_word_t      switch_out_3,
	output logic            switch_valid_0,
	output logic            switch_valid_1,
	output logic            switch_valid_2,
	output logic            switch_valid_3
);

	spad_word_t sw_in    [`SPAD_NUM_BG];
	spad_word_t sw_out   [`SPAD_NUM_BG];
	logic       sw_valid [`SPAD_NUM_BG];

	// Lane returns, group i takes lane i.
	assign sw_in[0] = switch_in_0;
	assign sw_in[1] = switch_in_1;
	assign sw_in[2] = switch_in_2;
	assign sw_in[3] = switch_in_3;

	// ================================================
	// Bank groups
	// ================================================

	for (genvar g = 0; g < `SPAD_NUM_BG; g++) begin : gen_bg
		spad_word_t feed_data;
		bg_mode_e   mode;

		// Select 1 stores the lane result, 0 the external word.
		assign feed_data = grp_sel[g] ? sw_in[g] : ext_word;
		assign mode      = bg_mode_e'(grp_mode[g]);

		bankgroup u_bg (
			.clk        (clk),
			.arst_n     (arst_n),
			.en         (grp_en[g]),
			.flush      (flush),
			.pattern    (mode),
			.din        (feed_data),
			.dout       (sw_out[g]),
			.dout_valid (sw_valid[g])
		);
	end

	// To the lanes.
	assign switch_out_0   = sw_out[0];
	assign switch_out_1   = sw_out[1];
	assign switch_out_2   = sw_out[2];
	assign switch_out_3   = sw_out[3];

	assign switch_valid_0 = sw_valid[0];
	assign switch_valid_1 = sw_valid[1];
	assign switch_valid_2 = sw_valid[2];
	assign switch_valid_3 = sw_valid[3];

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+common
common/spad_pkg.sv
verilog/inst_decoder.sv
scratchpad/bankgroup.sv
scratchpad/scratchpad.sv
verilog/lane_alu.sv
verilog/spad_top.sv
testbench/tb_spad_top.sv

// ==== testbench/tb_spad_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "spad_params.svh"

module tb_spad_top
	import spad_pkg::*;
;

	logic       clk = 1'b0;
	logic       arst_n;
	spad_inst_t inst;
	spad_word_t ext_word;
	logic       flush;

	spad_word_t rd_data_0, rd_data_1, rd_data_2, rd_data_3;
	logic       rd_valid_0, rd_valid_1, rd_valid_2, rd_valid_3;
	spad_word_t acc_0, acc_1, acc_2, acc_3;

	spad_word_t dut_data [`SPAD_NUM_BG];
	spad_word_t dut_acc  [`SPAD_NUM_BG];
	logic [`SPAD_NUM_BG-1:0] dut_valid;

	// Reference model state.
	spad_word_t m_q      [`SPAD_NUM_BG][$];
	spad_word_t m_acc    [`SPAD_NUM_BG];
	spad_word_t exp_data [`SPAD_NUM_BG];
	logic [`SPAD_NUM_BG-1:0] exp_valid;
	spad_grp_t  d_en;
	spad_grp_t  d_sel;
	spad_grp_t  d_mode;
	spad_word_t d_ext;
	logic       d_flush;

	logic       checks_on = 1'b0;
	int         strobes = 0;
	spad_word_t lcg_state = 32'd1;
	string      test_name = "reset";

	always #5 clk = ~clk;

	spad_top dut (
		.clk        (clk),
		.arst_n     (arst_n),
		.inst       (inst),
		.ext_word   (ext_word),
		.flush      (flush),
		.rd_data_0  (rd_data_0),
		.rd_data_1  (rd_data_1),
		.rd_data_2  (rd_data_2),
		.rd_data_3  (rd_data_3),
		.rd_valid_0 (rd_valid_0),
		.rd_valid_1 (rd_valid_1),
		.rd_valid_2 (rd_valid_2),
		.rd_valid_3 (rd_valid_3),
		.acc_0      (acc_0),
		.acc_1      (acc_1),
		.acc_2      (acc_2),
		.acc_3      (acc_3)
	);

	assign dut_data[0] = rd_data_0;
	assign dut_data[1] = rd_data_1;
	assign dut_data[2] = rd_data_2;
	assign dut_data[3] = rd_data_3;
	assign dut_acc[0]  = acc_0;
	assign dut_acc[1]  = acc_1;
	assign dut_acc[2]  = acc_2;
	assign dut_acc[3]  = acc_3;
	assign dut_valid   = {rd_valid_3, rd_valid_2, rd_valid_1, rd_valid_0};

	function automatic spad_word_t lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string what, input int grp,
			input spad_word_t exp_v, input spad_word_t act_v);
		abort_run($sformatf("ERROR %s lane %0d %s expected %h actual %h",
			test_name, grp, what, exp_v, act_v));
	endtask

	// ================================================
	// Reference model
	// ================================================

	// Lane stage uses the strobe of the previous edge, the fill source the acc before this edge.
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int g = 0; g < `SPAD_NUM_BG; g++) begin
				m_q[g].delete();
				m_acc[g]    <= '0;
				exp_data[g] <= '0;
			end
			exp_valid <= '0;
			d_en      <= '0;
			d_sel     <= '0;
			d_mode    <= '0;
			d_ext     <= '0;
			d_flush   <= 1'b0;
		end else begin
			for (int g = 0; g < `SPAD_NUM_BG; g++) begin
				if (d_flush) begin
					m_acc[g] <= '0;
				end else if (exp_valid[g]) begin
					m_acc[g] <= m_acc[g] + exp_data[g];
				end
				if (d_flush) begin
					m_q[g].delete();
					exp_valid[g] <= 1'b0;
				end else if (d_en[g] && d_mode[g]) begin
					if (m_q[g].size() == 0) begin
						abort_run($sformatf("Test %s drained empty group %0d", test_name, g));
					end
					exp_data[g]  <= m_q[g].pop_front();
					exp_valid[g] <= 1'b1;
				end else begin
					exp_valid[g] <= 1'b0;
				end
				if (!d_flush && d_en[g] && !d_mode[g]) begin
					m_q[g].push_back(d_sel[g] ? m_acc[g] : d_ext);
				end
			end
			d_en    <= flush ? '0 : inst[11:8];
			d_sel   <= inst[7:4];
			d_mode  <= inst[3:0];
			d_ext   <= ext_word;
			d_flush <= flush;
		end
	end

	always @(negedge clk) begin
		strobes <= strobes + int'(rd_valid_0) + int'(rd_valid_1)
			+ int'(rd_valid_2) + int'(rd_valid_3);
	end

	// ================================================
	// Checks
	// ================================================

	for (genvar g = 0; g < `SPAD_NUM_BG; g++) begin : gen_chk
		assert property (@(posedge clk) disable iff (!checks_on)
			dut_valid[g] == exp_valid[g])
		else report_mismatch("rd_valid", g, 32'($sampled(exp_valid[g])),
			32'($sampled(dut_valid[g])));

		assert property (@(posedge clk) disable iff (!checks_on)
			exp_valid[g] |-> dut_data[g] == exp_data[g])
		else report_mismatch("rd_data", g, $sampled(exp_data[g]), $sampled(dut_data[g]));

		assert property (@(posedge clk) disable iff (!checks_on)
			dut_acc[g] == m_acc[g])
		else report_mismatch("acc", g, $sampled(m_acc[g]), $sampled(dut_acc[g]));
	end

	// ================================================
	// Stimulus
	// ================================================

	task automatic issue(input spad_grp_t en, input spad_grp_t sel, input spad_grp_t mode,
			input spad_word_t word, input logic fl);
		@(posedge clk);
		inst     <= {en, sel, mode};
		ext_word <= word;
		flush    <= fl;
	endtask

	task automatic wait_strobes(input int base, input int n);
		int cycles;
		cycles = 0;
		issue('0, '0, '0, '0, 1'b0);
		while (strobes < base + n) begin
			@(negedge clk);
			cycles++;
			if (cycles > 100) begin
				abort_run($sformatf("Timed out in %s waiting for %0d read strobes",
					test_name, n));
			end
		end
	endtask

	initial begin
		int base;
		arst_n   = 1'b0;
		inst     = '0;
		ext_word = '0;
		flush    = 1'b0;
		@(negedge clk);
		checks_on = 1'b1;
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;
		repeat (2) @(posedge clk);

		test_name = "fill_drain";
		base = strobes;
		repeat (6) issue(4'b0001, 4'b0000, 4'b0000, lcg_next(), 1'b0);
		repeat (6) issue(4'b0001, 4'b0000, 4'b0001, lcg_next(), 1'b0);
		wait_strobes(base, 6);

		// Group 1 drains while group 3 fills, group 2 idles.
		test_name = "independence";
		base = strobes;
		repeat (3) issue(4'b0010, 4'b0000, 4'b0000, lcg_next(), 1'b0);
		repeat (3) issue(4'b0100, 4'b0000, 4'b0000, lcg_next(), 1'b0);
		repeat (3) issue(4'b1010, 4'b0000, 4'b0010, lcg_next(), 1'b0);
		repeat (3) issue(4'b1100, 4'b0000, 4'b1100, lcg_next(), 1'b0);
		wait_strobes(base, 9);

		test_name = "writeback";
		base = strobes;
		repeat (2) issue(4'b0011, 4'b0011, 4'b0000, lcg_next(), 1'b0);
		repeat (2) issue(4'b0011, 4'b0000, 4'b0011, lcg_next(), 1'b0);
		wait_strobes(base, 4);

		// Flush lands one cycle after a drain and carries a drain of its own.
		test_name = "flush";
		base = strobes;
		repeat (2) issue(4'b1111, 4'b0000, 4'b0000, lcg_next(), 1'b0);
		issue(4'b0001, 4'b0000, 4'b0001, lcg_next(), 1'b0);
		issue(4'b1111, 4'b0000, 4'b1111, lcg_next(), 1'b1);
		repeat (2) issue(4'b0100, 4'b0000, 4'b0000, lcg_next(), 1'b0);
		repeat (2) issue(4'b0100, 4'b0000, 4'b0100, lcg_next(), 1'b0);
		wait_strobes(base, 3);

		test_name = "wrap";
		base = strobes;
		repeat (3) issue(4'b1000, 4'b0000, 4'b0000, lcg_next(), 1'b0);
		repeat (18) begin
			issue(4'b1000, 4'b0000, 4'b0000, lcg_next(), 1'b0);
			issue(4'b1000, 4'b0000, 4'b1000, lcg_next(), 1'b0);
		end
		repeat (3) issue(4'b1000, 4'b0000, 4'b1000, lcg_next(), 1'b0);
		wait_strobes(base, 21);

		// Last acc update lands one edge after the last strobe.
		repeat (3) @(posedge clk);
		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/inst_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "spad_params.svh"

module inst_decoder
	import spad_pkg::*;
(
	input  wire logic       clk,
	input  wire logic       arst_n,
	input  wire spad_inst_t inst,
	input  wire spad_word_t ext_word,
	input  wire logic       flush,
	output spad_grp_t       grp_en,
	output spad_grp_t       grp_sel,
	output spad_grp_t       grp_mode,
	output spad_word_t      ext_word_q,
	output logic            flush_q
);

	spad_grp_t inst_en;
	spad_grp_t inst_sel;
	spad_grp_t inst_mode;

	// Enables sit on top and modes at the bottom.
	assign inst_en   = inst[3*`SPAD_NUM_BG-1:2*`SPAD_NUM_BG];
	assign inst_sel  = inst[2*`SPAD_NUM_BG-1:`SPAD_NUM_BG];
	assign inst_mode = inst[`SPAD_NUM_BG-1:0];

	// ================================================
	// Decode register
	// ================================================

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			grp_en     <= '0;
			grp_sel    <= '0;
			grp_mode   <= {`SPAD_NUM_BG{BG_FILL}};
			ext_word_q <= '0;
			flush_q    <= 1'b0;
		end else begin
			// A flush cycle carries no group operation.
			if (flush) begin
				grp_en <= '0;
			end else begin
				grp_en <= inst_en;
			end
			grp_sel    <= inst_sel;
			grp_mode   <= inst_mode;
			ext_word_q <= ext_word;
			flush_q    <= flush;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/lane_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module lane_alu
	import spad_pkg::*;
(
	input  wire logic       clk,
	input  wire logic       arst_n,
	input  wire logic       flush,
	input  wire spad_word_t din,
	input  wire logic       din_valid,
	output spad_word_t      acc
);

	spad_word_t acc_sum;

	// Sum wraps at the word width.
	assign acc_sum = acc + din;

	// ================================================
	// Accumulator
	// ================================================

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			acc <= '0;
		end else if (flush) begin
			acc <= '0;
		end else if (din_valid) begin
			acc <= acc_sum;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/spad_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module spad_top
	import spad_pkg::*;
(
	input  wire logic       clk,
	input  wire logic       arst_n,
	input  wire spad_inst_t inst,
	input  wire spad_word_t ext_word,
	input  wire logic       flush,
	output spad_word_t      rd_data_0,
	output spad_word_t      rd_data_1,
	output spad_word_t      rd_data_2,
	output spad_word_t      rd_data_3,
	output logic            rd_valid_0,
	output logic            rd_valid_1,
	output logic            rd_valid_2,
	output logic            rd_valid_3,
	output spad_word_t      acc_0,
	output spad_word_t      acc_1,
	output spad_word_t      acc_2,
	output spad_word_t      acc_3
);

	spad_grp_t  grp_en;
	spad_grp_t  grp_sel;
	spad_grp_t  grp_mode;
	spad_word_t ext_word_q;
	logic       flush_q;

	// ================================================
	// Decode stage
	// ================================================

	inst_decoder u_dec (
		.clk        (clk),
		.arst_n     (arst_n),
		.inst       (inst),
		.ext_word   (ext_word),
		.flush      (flush),
		.grp_en     (grp_en),
		.grp_sel    (grp_sel),
		.grp_mode   (grp_mode),
		.ext_word_q (ext_word_q),
		.flush_q    (flush_q)
	);

	// ================================================
	// Scratchpad stage
	// ================================================

	// Lane sums come back as the switch inputs.
	scratchpad u_spad (
		.clk            (clk),
		.arst_n         (arst_n),
		.grp_en         (grp_en),
		.grp_sel        (grp_sel),
		.grp_mode       (grp_mode),
		.ext_word       (ext_word_q),
		.flush          (flush_q),
		.switch_in_0    (acc_0),
		.switch_in_1    (acc_1),
		.switch_in_2    (acc_2),
		.switch_in_3    (acc_3),
		.switch_out_0   (rd_data_0),
		.switch_out_1   (rd_data_1),
		.switch_out_2   (rd_data_2),
		.switch_out_3   (rd_data_3),
		.switch_valid_0 (rd_valid_0),
		.switch_valid_1 (rd_valid_1),
		.switch_valid_2 (rd_valid_2),
		.switch_valid_3 (rd_valid_3)
	);

	// ================================================
	// Lanes
	// ================================================

	lane_alu u_lane_0 (
		.clk       (clk),
		.arst_n    (arst_n),
		.flush     (flush_q),
		.din       (rd_data_0),
		.din_valid (rd_valid_0),
		.acc       (acc_0)
	);

	lane_alu u_lane_1 (
		.clk       (clk),
		.arst_n    (arst_n),
		.flush     (flush_q),
		.din       (rd_data_1),
		.din_valid (rd_valid_1),
		.acc       (acc_1)
	);

	lane_alu u_lane_2 (
		.clk       (clk),
		.arst_n    (arst_n),
		.flush     (flush_q),
		.din       (rd_data_2),
		.din_valid (rd_valid_2),
		.acc       (acc_2)
	);

	lane_alu u_lane_3 (
		.clk       (clk),
		.arst_n    (arst_n),
		.flush     (flush_q),
		.din       (rd_data_3),
		.din_valid (rd_valid_3),
		.acc       (acc_3)
	);

endmodule

`default_nettype wire
